/* bench/nearest_centroid_asserts.sv */
`timescale 1ns/1ps
// Concurrent checks on the credit rules of the sample buffer and the result stage
module nearest_centroid_asserts (
    input logic                                          clk,
    input logic                                          rst_n,
    input logic                                          in_valid,
    input logic                                          in_credit,
    input logic                                          out_valid,
    input logic                                          out_credit,
    input logic [vq_flow_pkg::fifo_addr_w:0]             fifo_count,
    input logic [$clog2(vq_flow_pkg::out_credits+1)-1:0] credit_cnt
);
    localparam int fifo_cnt_w   = vq_flow_pkg::fifo_addr_w + 1;
    localparam int credit_cnt_w = $clog2(vq_flow_pkg::out_credits + 1);

    // Credits held by each side, rebuilt from the port pulses
    int out_left;
    int up_left;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_left <= vq_flow_pkg::out_credits;
            up_left  <= vq_flow_pkg::fifo_depth;
        end
        else
        begin
            out_left <= out_left - int'(out_valid) + int'(out_credit);
            up_left  <= up_left - int'(in_valid) + int'(in_credit);
        end
    end

    // --------------------
    // Output side
    // --------------------
    a_send_needs_credit: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> (out_left > 0)
    ) else $error("Result sent while the output credit count was zero");

    a_credit_limit: assert property (
        @(posedge clk) disable iff (!rst_n)
        credit_cnt <= credit_cnt_w'(vq_flow_pkg::out_credits)
    ) else $error("Output credit count above the downstream grant");

    // --------------------
    // Input side
    // --------------------
    // Upstream credits, buffered samples and pending credit pulses add up to the depth
    a_credit_per_read: assert property (
        @(posedge clk) disable iff (!rst_n)
        (up_left + int'(fifo_count) + int'(in_credit)) == vq_flow_pkg::fifo_depth
    ) else $error("Credit pulses returned without matching buffer reads");

    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid |-> (fifo_count != fifo_cnt_w'(vq_flow_pkg::fifo_depth))
    ) else $error("Sample written while the buffer was full");

endmodule

bind nearest_centroid_top nearest_centroid_asserts i_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_credit (in_credit),
    .out_valid (out_valid),
    .out_credit(out_credit),
    .fifo_count(i_sample_fifo.count),
    .credit_cnt(i_result_stage.credit_cnt)
);

/* bench/tb_nearest_centroid.sv */
`timescale 1ns/1ps
// Testbench for the nearest-centroid classifier
// Loads centroids and samples from a file and checks every result in order
module tb_nearest_centroid;

    logic                            clk;
    logic                            rst_n;
    logic                            cfg_we;
    logic [vq_data_pkg::index_w-1:0] cfg_addr;
    logic [vq_data_pkg::coord_w-1:0] cfg_x;
    logic [vq_data_pkg::coord_w-1:0] cfg_y;
    logic                            in_valid;
    logic [vq_data_pkg::coord_w-1:0] in_x;
    logic [vq_data_pkg::coord_w-1:0] in_y;
    logic                            in_credit;
    logic                            out_credit;
    logic                            out_valid;
    logic [vq_data_pkg::index_w-1:0] out_index;
    logic [vq_data_pkg::dist_w-1:0]  out_dist;

    // Stimulus in file order
    int cent_idx_q[$];
    int cent_x_q[$];
    int cent_y_q[$];
    int smp_x_q[$];
    int smp_y_q[$];
    int smp_idx_q[$];
    int smp_dist_q[$];

    int n_samples    = 0;
    int error_count  = 0;
    int samples_sent = 0;
    int credits_seen = 0;
    int results_seen = 0;
    int credits_back = 0;
    bit first_sent   = 1'b0;
    bit stim_loaded  = 1'b0;

    nearest_centroid_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_x     (cfg_x),
        .cfg_y     (cfg_y),
        .in_valid  (in_valid),
        .in_x      (in_x),
        .in_y      (in_y),
        .in_credit (in_credit),
        .out_credit(out_credit),
        .out_valid (out_valid),
        .out_index (out_index),
        .out_dist  (out_dist)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t: %s (got %0d, expected %0d)",
                     $time, what, actual, expected);
            error_count = error_count + 1;
        end
    endtask

    // --------------------
    // Stimulus file
    // --------------------
    task automatic load_stimulus();
        int                fd;
        int                code;
        int                a;
        int                b;
        int                c;
        int                d;
        logic [7:0]        tag;
        logic [8*160-1:0]  rest;
        fd = $fopen("bench/vq_stimulus.txt", "r");
        if (fd == 0)
            $display("Cannot open the stimulus file bench/vq_stimulus.txt");
        else
        begin
            while (!$feof(fd))
            begin
                code = $fscanf(fd, "%s", tag);
                if (code != 1)
                    break;
                if (tag == "c")
                begin
                    code = $fscanf(fd, "%d %d %d", a, b, c);
                    cent_idx_q.push_back(a);
                    cent_x_q.push_back(b);
                    cent_y_q.push_back(c);
                end
                else if (tag == "s")
                begin
                    code = $fscanf(fd, "%d %d %d %d", a, b, c, d);
                    smp_x_q.push_back(a);
                    smp_y_q.push_back(b);
                    smp_idx_q.push_back(c);
                    smp_dist_q.push_back(d);
                end
                else
                    code = $fgets(rest, fd);
            end
            $fclose(fd);
        end
        n_samples = smp_x_q.size();
    endtask

    task automatic load_centroids();
        for (int i = 0; i < cent_idx_q.size(); i++)
        begin
            @(posedge clk);
            cfg_we   <= 1'b1;
            cfg_addr <= vq_data_pkg::index_w'(cent_idx_q[i]);
            cfg_x    <= vq_data_pkg::coord_w'(cent_x_q[i]);
            cfg_y    <= vq_data_pkg::coord_w'(cent_y_q[i]);
        end
        @(posedge clk);
        cfg_we <= 1'b0;
    endtask

    // Upstream model, bursts of four with a pause between bursts
    task automatic send_samples();
        int gap;
        gap = 0;
        while (samples_sent < n_samples)
        begin
            @(posedge clk);
            if (gap > 0)
            begin
                in_valid <= 1'b0;
                gap = gap - 1;
            end
            else if (vq_flow_pkg::fifo_depth - samples_sent + credits_seen > 0)
            begin
                in_valid <= 1'b1;
                in_x     <= vq_data_pkg::coord_w'(smp_x_q[samples_sent]);
                in_y     <= vq_data_pkg::coord_w'(smp_y_q[samples_sent]);
                first_sent = 1'b1;
                samples_sent = samples_sent + 1;
                if (samples_sent % 4 == 0)
                    gap = 2 + (samples_sent / 4) % 5;
            end
            else
                in_valid <= 1'b0;
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // --------------------
    // Downstream credit return, random delay of 0 to 5 cycles
    // --------------------
    initial
    begin : downstream
        int          cycle;
        int          due_q[$];
        logic [31:0] rng_state;
        cycle      = 0;
        rng_state  = 32'd44622;
        out_credit = 1'b0;
        @(posedge clk);
        forever
        begin
            @(negedge clk);
            if (out_valid === 1'b1)
            begin
                rng_state = xorshift32(rng_state);
                due_q.push_back(cycle + 1 + int'(rng_state % 32'd6));
            end
            @(posedge clk);
            cycle = cycle + 1;
            if (due_q.size() > 0 && due_q[0] <= cycle)
            begin
                out_credit <= 1'b1;
                void'(due_q.pop_front());
            end
            else
                out_credit <= 1'b0;
        end
    end

    // Outputs are sampled on the falling edge
    initial
    begin : monitor
        @(posedge clk);
        forever
        begin
            @(negedge clk);
            if (!first_sent)
            begin
                check_value(32'(out_valid), 0, "out_valid low before the first sample");
                check_value(32'(in_credit), 0, "in_credit low before the first sample");
            end
            if (in_credit === 1'b1)
                credits_seen = credits_seen + 1;
            if (out_credit === 1'b1)
                credits_back = credits_back + 1;
            if (out_valid === 1'b1)
            begin
                if (results_seen < n_samples)
                begin
                    check_value(32'(out_index), smp_idx_q[results_seen],
                                $sformatf("index of result %0d", results_seen));
                    check_value(32'(out_dist), smp_dist_q[results_seen],
                                $sformatf("distance of result %0d", results_seen));
                end
                else
                begin
                    $display("Extra result at %0t, more results than samples", $time);
                    error_count = error_count + 1;
                end
                results_seen = results_seen + 1;
            end
            check_value(32'(results_seen - credits_back <= vq_flow_pkg::out_credits), 1,
                        "results in flight within the output credit grant");
        end
    end

    initial
    begin : watchdog
        wait (stim_loaded);
        repeat (n_samples * 40 + 200) @(posedge clk);
        $display("Timeout: only %0d of %0d results arrived", results_seen, n_samples);
        $display("Checks failed");
        $finish;
    end

    initial
    begin : main
        rst_n    = 1'b0;
        cfg_we   = 1'b0;
        cfg_addr = '0;
        cfg_x    = '0;
        cfg_y    = '0;
        in_valid = 1'b0;
        in_x     = '0;
        in_y     = '0;
        load_stimulus();
        if (n_samples == 0)
        begin
            $display("No samples could be read, nothing to run");
            $display("Checks failed");
            $finish;
        end
        else
        begin
            stim_loaded = 1'b1;
            repeat (16) @(posedge clk);
            rst_n <= 1'b1;
            load_centroids();
            send_samples();
            wait (results_seen >= n_samples);
            repeat (10) @(posedge clk);
            check_value(results_seen, n_samples, "total result count");
            check_value(credits_seen, samples_sent, "in_credit pulses against samples sent");
            $display("Run finished: %0d samples, %0d results, %0d errors",
                     samples_sent, results_seen, error_count);
            if (error_count == 0)
                $display("All checks passed");
            else
                $display("Checks failed");
            $finish;
        end
    end

endmodule

/* bench/vq_stimulus.txt */
# c <index> <x> <y>  loads one centroid
# s <x> <y> <expected index> <expected distance>  one sample and its nearest centroid
c 0 3000 3000
c 1 3995 100
c 2 100 4000
c 3 1000 1000
c 4 3900 3900
c 5 2000 3500
c 6 3500 2000
c 7 500 2500
c 8 2500 500
c 9 4095 4095
c 10 0 0
c 11 3000 3000
c 12 1200 1200
c 13 2200 2200
c 14 4095 0
c 15 0 4095
# exact hit on centroids 0 and 11
s 3000 3000 0 0
s 10 20 10 30
s 4090 4000 9 100
# tie between 3 and 12 across the tree halves
s 1100 1100 3 200
s 2210 2190 13 20
s 520 2480 7 40
s 2500 500 8 0
# tie between 1 and 14
s 4045 50 1 100
s 3600 2100 6 200
s 1950 3600 5 150
s 100 3900 2 100
# tie between 3 and 12 again
s 1000 1200 3 200
s 5 4090 15 10
s 4095 10 14 10
s 3950 3850 4 100
# tie between 0 and 11
s 2900 3100 0 200
s 1200 1250 12 50
s 4095 4095 9 0
s 0 0 10 0
s 2000 1990 13 410

/* design/centroid_table.sv */
`timescale 1ns/1ps
// Centroid register file, sixteen coordinate pairs
// Written one entry per cycle, presented flattened with index 0 low
module centroid_table (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic                                                  cfg_we,
    input  logic [vq_data_pkg::index_w-1:0]                       cfg_addr,
    input  logic [vq_data_pkg::coord_w-1:0]                       cfg_x,
    input  logic [vq_data_pkg::coord_w-1:0]                       cfg_y,
    output logic [vq_data_pkg::n_centroids*vq_data_pkg::coord_w-1:0] cent_x,
    output logic [vq_data_pkg::n_centroids*vq_data_pkg::coord_w-1:0] cent_y
);
    logic [vq_data_pkg::coord_w-1:0] tab_x [vq_data_pkg::n_centroids];
    logic [vq_data_pkg::coord_w-1:0] tab_y [vq_data_pkg::n_centroids];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < vq_data_pkg::n_centroids; i++)
            begin
                tab_x[i] <= '0;
                tab_y[i] <= '0;
            end
        end
        else if (cfg_we)
        begin
            tab_x[cfg_addr] <= cfg_x;
            tab_y[cfg_addr] <= cfg_y;
        end
    end

    // --------------------
    // Flattened view
    // --------------------
    genvar g;
    generate
        for (g = 0; g < vq_data_pkg::n_centroids; g++)
        begin : g_flat
            assign cent_x[g*vq_data_pkg::coord_w +: vq_data_pkg::coord_w] = tab_x[g];
            assign cent_y[g*vq_data_pkg::coord_w +: vq_data_pkg::coord_w] = tab_y[g];
        end
    endgenerate

endmodule

/* design/distance_array.sv */
`timescale 1ns/1ps
// First pipeline stage: sixteen Manhattan-distance units
// Distances to every centroid are registered together with one valid bit
module distance_array (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic                                                  rd_valid,
    input  logic [vq_data_pkg::coord_w-1:0]                       rd_x,
    input  logic [vq_data_pkg::coord_w-1:0]                       rd_y,
    input  logic [vq_data_pkg::n_centroids*vq_data_pkg::coord_w-1:0] cent_x,
    input  logic [vq_data_pkg::n_centroids*vq_data_pkg::coord_w-1:0] cent_y,
    input  logic                                                  advance,
    output logic                                                  rd_en,
    output logic                                                  dist_valid,
    output logic [vq_data_pkg::n_centroids*vq_data_pkg::dist_w-1:0]  dist_array
);
    logic [vq_data_pkg::n_centroids*vq_data_pkg::dist_w-1:0] dist_next;

    // Pop the buffer only when the register can take the sample
    assign rd_en = rd_valid && advance;

    // --------------------
    // Distance units
    // --------------------
    genvar g;
    generate
        for (g = 0; g < vq_data_pkg::n_centroids; g++)
        begin : g_unit
            logic [vq_data_pkg::coord_w-1:0] cx;
            logic [vq_data_pkg::coord_w-1:0] cy;
            logic [vq_data_pkg::coord_w-1:0] dx;
            logic [vq_data_pkg::coord_w-1:0] dy;

            assign cx = cent_x[g*vq_data_pkg::coord_w +: vq_data_pkg::coord_w];
            assign cy = cent_y[g*vq_data_pkg::coord_w +: vq_data_pkg::coord_w];

            // Absolute differences per axis
            assign dx = (rd_x >= cx) ? (rd_x - cx) : (cx - rd_x);
            assign dy = (rd_y >= cy) ? (rd_y - cy) : (cy - rd_y);

            assign dist_next[g*vq_data_pkg::dist_w +: vq_data_pkg::dist_w] =
                vq_data_pkg::dist_w'(dx) + vq_data_pkg::dist_w'(dy);
        end
    endgenerate

    // --------------------
    // Stage register
    // --------------------
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            dist_valid <= 1'b0;
        else if (advance)
            dist_valid <= rd_valid;
    end

    always_ff @(posedge clk)
    begin
        if (rd_en)
            dist_array <= dist_next;
    end

endmodule

/* design/min_16.sv */
`timescale 1ns/1ps
// Sixteen-way minimum tree, purely combinational
// Pair leaves, then three layers of min_node; ties go to the lower index
module min_16 (
    input  logic [vq_data_pkg::n_centroids*vq_data_pkg::dist_w-1:0] min_array,
    output logic [vq_data_pkg::dist_w-1:0]                         min,
    output logic [vq_data_pkg::index_w-1:0]                        min_index
);
    localparam int ew = vq_data_pkg::dist_w;

    logic [ew*8-1:0] min_l1;
    logic [8*1-1:0]  index_l1;
    logic [ew*4-1:0] min_l2;
    logic [4*2-1:0]  index_l2;
    logic [ew*2-1:0] min_l3;
    logic [2*3-1:0]  index_l3;
    logic [ew-1:0]   min_l4;
    logic [1*4-1:0]  index_l4;

    genvar i;
    generate
        // --------------------
        // Leaf layer, eight pairs
        // --------------------
        for (i = 0; i < 8; i++)
        begin : g_leaf
            logic [ew-1:0] e0;
            logic [ew-1:0] e1;

            assign e0          = min_array[(2*i)*ew +: ew];
            assign e1          = min_array[(2*i+1)*ew +: ew];
            assign index_l1[i] = (e1 < e0);
            assign min_l1[i*ew +: ew] = index_l1[i] ? e1 : e0;
        end

        // --------------------
        // Inner layers
        // --------------------
        for (i = 0; i < 4; i++)
        begin : g_l2
            min_node #(
                .prev_index_w(1)
            ) i_node (
                .element0       (min_l1[(2*i)*ew +: ew]),
                .element1       (min_l1[(2*i+1)*ew +: ew]),
                .previous_index0(index_l1[2*i +: 1]),
                .previous_index1(index_l1[2*i+1 +: 1]),
                .element        (min_l2[i*ew +: ew]),
                .index          (index_l2[i*2 +: 2])
            );
        end

        for (i = 0; i < 2; i++)
        begin : g_l3
            min_node #(
                .prev_index_w(2)
            ) i_node (
                .element0       (min_l2[(2*i)*ew +: ew]),
                .element1       (min_l2[(2*i+1)*ew +: ew]),
                .previous_index0(index_l2[i*4 +: 2]),
                .previous_index1(index_l2[i*4+2 +: 2]),
                .element        (min_l3[i*ew +: ew]),
                .index          (index_l3[i*3 +: 3])
            );
        end

        // Root compares the two halves
        min_node #(
            .prev_index_w(3)
        ) i_root (
            .element0       (min_l3[0 +: ew]),
            .element1       (min_l3[ew +: ew]),
            .previous_index0(index_l3[0 +: 3]),
            .previous_index1(index_l3[3 +: 3]),
            .element        (min_l4),
            .index          (index_l4)
        );
    endgenerate

    assign min       = min_l4;
    assign min_index = index_l4;

endmodule

/* design/min_node.sv */
`timescale 1ns/1ps
// Inner comparator of the minimum tree
// Keeps the smaller key and extends the winner's index by one bit
module min_node #(
    parameter int prev_index_w = 1
) (
    input  logic [vq_data_pkg::dist_w-1:0] element0,
    input  logic [vq_data_pkg::dist_w-1:0] element1,
    input  logic [prev_index_w-1:0]        previous_index0,
    input  logic [prev_index_w-1:0]        previous_index1,
    output logic [vq_data_pkg::dist_w-1:0] element,
    output logic [prev_index_w:0]          index
);
    logic pick1;

    // Strictly smaller only, so element0 keeps ties
    assign pick1 = (element1 < element0);

    always_comb
    begin
        if (pick1)
        begin
            element = element1;
            index   = {1'b1, previous_index1};
        end
        else
        begin
            element = element0;
            index   = {1'b0, previous_index0};
        end
    end

endmodule

/* design/nearest_centroid_top.sv */
`timescale 1ns/1ps
// Nearest-centroid classifier, top level
// Credited samples in, index and distance of the closest centroid out
module nearest_centroid_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cfg_we,
    input  logic [vq_data_pkg::index_w-1:0] cfg_addr,
    input  logic [vq_data_pkg::coord_w-1:0] cfg_x,
    input  logic [vq_data_pkg::coord_w-1:0] cfg_y,
    input  logic                            in_valid,
    input  logic [vq_data_pkg::coord_w-1:0] in_x,
    input  logic [vq_data_pkg::coord_w-1:0] in_y,
    output logic                            in_credit,
    input  logic                            out_credit,
    output logic                            out_valid,
    output logic [vq_data_pkg::index_w-1:0] out_index,
    output logic [vq_data_pkg::dist_w-1:0]  out_dist
);
    logic                                                    rd_valid;
    logic [vq_data_pkg::coord_w-1:0]                         rd_x;
    logic [vq_data_pkg::coord_w-1:0]                         rd_y;
    logic                                                    rd_en;
    logic [vq_data_pkg::n_centroids*vq_data_pkg::coord_w-1:0] cent_x;
    logic [vq_data_pkg::n_centroids*vq_data_pkg::coord_w-1:0] cent_y;
    logic                                                    dist_valid;
    logic [vq_data_pkg::n_centroids*vq_data_pkg::dist_w-1:0]  dist_array;
    logic                                                    advance;

    sample_fifo i_sample_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_x     (in_x),
        .in_y     (in_y),
        .rd_en    (rd_en),
        .rd_valid (rd_valid),
        .rd_x     (rd_x),
        .rd_y     (rd_y),
        .in_credit(in_credit)
    );

    centroid_table i_centroid_table (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg_we  (cfg_we),
        .cfg_addr(cfg_addr),
        .cfg_x   (cfg_x),
        .cfg_y   (cfg_y),
        .cent_x  (cent_x),
        .cent_y  (cent_y)
    );

    distance_array i_distance_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_valid  (rd_valid),
        .rd_x      (rd_x),
        .rd_y      (rd_y),
        .cent_x    (cent_x),
        .cent_y    (cent_y),
        .advance   (advance),
        .rd_en     (rd_en),
        .dist_valid(dist_valid),
        .dist_array(dist_array)
    );

    result_stage i_result_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .dist_valid(dist_valid),
        .dist_array(dist_array),
        .out_credit(out_credit),
        .advance   (advance),
        .out_valid (out_valid),
        .out_index (out_index),
        .out_dist  (out_dist)
    );

endmodule

/* design/result_stage.sv */
`timescale 1ns/1ps
// Output stage: tree minimum registered and sent against downstream credits
// Also tells the distance stage when it may advance
module result_stage (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  logic                                                   dist_valid,
    input  logic [vq_data_pkg::n_centroids*vq_data_pkg::dist_w-1:0] dist_array,
    input  logic                                                   out_credit,
    output logic                                                   advance,
    output logic                                                   out_valid,
    output logic [vq_data_pkg::index_w-1:0]                        out_index,
    output logic [vq_data_pkg::dist_w-1:0]                         out_dist
);
    localparam int cnt_w = $clog2(vq_flow_pkg::out_credits + 1);

    logic [cnt_w-1:0]                credit_cnt;
    logic                            have_credit;
    logic                            send;
    logic [vq_data_pkg::dist_w-1:0]  tree_min;
    logic [vq_data_pkg::index_w-1:0] tree_index;

    min_16 i_min_16 (
        .min_array(dist_array),
        .min      (tree_min),
        .min_index(tree_index)
    );

    assign have_credit = (credit_cnt != '0);
    assign send        = dist_valid && have_credit;

    // Distance register may reload when empty or when it drains this cycle
    assign advance = !dist_valid || have_credit;

    // --------------------
    // Credit counter
    // --------------------
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            credit_cnt <= cnt_w'(vq_flow_pkg::out_credits);
        else
        begin
            case ({send, out_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // Result register and send pulse
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            out_valid <= 1'b0;
        else
            out_valid <= send;
    end

    always_ff @(posedge clk)
    begin
        if (send)
        begin
            out_index <= tree_index;
            out_dist  <= tree_min;
        end
    end

endmodule

/* design/sample_fifo.sv */
`timescale 1ns/1ps
// Receive buffer for credited samples
// Each read frees one entry and returns one credit upstream
module sample_fifo (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  logic [vq_data_pkg::coord_w-1:0] in_x,
    input  logic [vq_data_pkg::coord_w-1:0] in_y,
    input  logic                            rd_en,
    output logic                            rd_valid,
    output logic [vq_data_pkg::coord_w-1:0] rd_x,
    output logic [vq_data_pkg::coord_w-1:0] rd_y,
    output logic                            in_credit
);
    localparam int cnt_w = vq_flow_pkg::fifo_addr_w + 1;

    logic [vq_data_pkg::coord_w-1:0]     mem_x [vq_flow_pkg::fifo_depth];
    logic [vq_data_pkg::coord_w-1:0]     mem_y [vq_flow_pkg::fifo_depth];
    logic [vq_flow_pkg::fifo_addr_w-1:0] wr_ptr;
    logic [vq_flow_pkg::fifo_addr_w-1:0] rd_ptr;
    logic [cnt_w-1:0]                    count;
    logic                                wr_ok;
    logic                                rd_ok;

    // Head entry is visible as soon as the count is nonzero
    assign rd_valid = (count != '0);
    assign rd_x     = mem_x[rd_ptr];
    assign rd_y     = mem_y[rd_ptr];

    assign wr_ok = in_valid && (count != cnt_w'(vq_flow_pkg::fifo_depth));
    assign rd_ok = rd_en && rd_valid;

    // Sample storage
    always_ff @(posedge clk)
    begin
        if (wr_ok)
        begin
            mem_x[wr_ptr] <= in_x;
            mem_y[wr_ptr] <= in_y;
        end
    end

    // Pointers wrap on their own, occupancy tracks both sides
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end
        else
        begin
            // One credit back for every pop
            in_credit <= rd_ok;
            if (wr_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_ok)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* design/vq_data_pkg.sv */
// Data widths for the nearest-centroid classifier
// Coordinates, Manhattan distances and centroid indexes
package vq_data_pkg;

    // --------------------
    // Sample and centroid coordinates
    // --------------------

    // One unsigned coordinate
    localparam int coord_w = 12;

    // --------------------
    // Distances and indexes
    // --------------------

    // Sum of two coordinate differences, largest value 8190
    localparam int dist_w = 14;

    // Number of centroids held in the table
    localparam int n_centroids = 16;

    // Centroid index, also the config write address
    localparam int index_w = 4;

endpackage

/* design/vq_flow_pkg.sv */
// Credit flow-control sizes for both sides of the classifier
package vq_flow_pkg;

    // Sample buffer entries, also the upstream credits after reset
    localparam int fifo_depth = 4;

    // Buffer pointer width, depth is a power of two
    localparam int fifo_addr_w = 2;

    // Result credits granted by the downstream after reset
    localparam int out_credits = 2;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build and run the nearest-centroid testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary -f sources.f --top-module tb_nearest_centroid -o sim_nearest_centroid \
    && ./obj_dir/sim_nearest_centroid > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log && echo "Simulation PASSED" || { echo "Simulation FAILED"; exit 1; }

/* sources.f */
design/vq_data_pkg.sv
design/vq_flow_pkg.sv
design/sample_fifo.sv
design/centroid_table.sv
design/distance_array.sv
design/min_node.sv
design/min_16.sv
design/result_stage.sv
design/nearest_centroid_top.sv
bench/nearest_centroid_asserts.sv
bench/tb_nearest_centroid.sv
